//--- all.f
verilog/cache_pkg.sv
verilog/cpu_port.sv
verilog/cache_store.sv
verilog/cache_ctrl.sv
verilog/cache_l1.sv
test/mem_model.sv
test/tb_cache_l1.sv

//--- Makefile
TOP = tb_cache_l1

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_cache_l1.sv
`timescale 1ns/100ps

module tb_cache_l1;
    import cache_pkg::*;

    localparam word_t mem_key  = 32'h5a3c_96e1;
    localparam int    max_wait = 200;

    logic     clk;
    logic     rst_n;
    logic     cpu_req;
    bus_req_t cpu_cmd;
    logic     cpu_ack;
    word_t    cpu_rdata;
    logic     mem_req;
    bus_req_t mem_cmd;
    logic     mem_ack;
    word_t    mem_rdata;
    int       rd_count;
    int       wr_count;
    addr_t    last_wr_addr;
    word_t    last_wr_data;
    logic     mem_stuck;

    // expected values and a shadow copy of memory
    word_t    ref_mem [addr_t];
    logic     started;
    logic     count_chk;
    logic     write_chk;
    word_t    exp_rdata;
    int       exp_reads;
    int       exp_writes;
    addr_t    exp_wr_addr;
    word_t    exp_wr_data;
    int       errors;
    int       tests_run;
    int       tests_failed;

    cache_l1 i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_cmd   (cpu_cmd),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    mem_model #(.fill_key(mem_key)) i_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req      (mem_req),
        .mem_cmd      (mem_cmd),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .rd_count     (rd_count),
        .wr_count     (wr_count),
        .last_wr_addr (last_wr_addr),
        .last_wr_data (last_wr_data),
        .stuck        (mem_stuck)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // nothing may move on either port before the first request
    a_quiet_before_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        !started |-> (!cpu_ack && !mem_req)
    ) else begin
        $display("[ERROR] %0t cpu_ack,mem_req expected 00 actual %b%b",
                 $time, $sampled(cpu_ack), $sampled(mem_req));
        errors++;
    end

    a_read_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($rose(cpu_ack) && !cpu_cmd.write) |-> (cpu_rdata == exp_rdata)
    ) else begin
        $display("[ERROR] %0t cpu_rdata expected %h actual %h",
                 $time, $sampled(exp_rdata), $sampled(cpu_rdata));
        errors++;
    end

    a_read_count: assert property (
        @(posedge clk) count_chk |-> (rd_count == exp_reads)
    ) else begin
        $display("[ERROR] %0t rd_count expected %0d actual %0d",
                 $time, $sampled(exp_reads), $sampled(rd_count));
        errors++;
    end

    a_write_count: assert property (
        @(posedge clk) count_chk |-> (wr_count == exp_writes)
    ) else begin
        $display("[ERROR] %0t wr_count expected %0d actual %0d",
                 $time, $sampled(exp_writes), $sampled(wr_count));
        errors++;
    end

    a_write_value: assert property (
        @(posedge clk) write_chk |-> (last_wr_addr == exp_wr_addr && last_wr_data == exp_wr_data)
    ) else begin
        $display("[ERROR] %0t last_wr_addr/last_wr_data expected %h/%h actual %h/%h",
                 $time, $sampled(exp_wr_addr), $sampled(exp_wr_data),
                 $sampled(last_wr_addr), $sampled(last_wr_data));
        errors++;
    end

    // one full four-phase access
    // reads is the number of memory reads the access should cost
    task automatic cpu_access(input logic wr, input addr_t addr, input word_t wdata,
                              input int reads);
        int guard;
        @(posedge clk);
        cpu_cmd   <= '{write: wr, addr: addr, wdata: wdata};
        cpu_req   <= 1'b1;
        started   <= 1'b1;
        exp_rdata <= ref_mem.exists(addr) ? ref_mem[addr] : (addr ^ mem_key);
        exp_reads <= exp_reads + reads;
        if (wr) begin
            ref_mem[addr] = wdata;
            exp_writes  <= exp_writes + 1;
            exp_wr_addr <= addr;
            exp_wr_data <= wdata;
        end
        guard = 0;
        while (!cpu_ack && guard < max_wait) begin
            @(posedge clk);
            guard++;
        end
        if (!cpu_ack) begin
            $display("timeout at %0t: cpu_ack never rose for address %h", $time, addr);
            errors++;
        end
        cpu_req <= 1'b0;
        guard = 0;
        while (cpu_ack && guard < max_wait) begin
            @(posedge clk);
            guard++;
        end
        if (cpu_ack) begin
            $display("timeout at %0t: cpu_ack stayed high after cpu_req fell", $time);
            errors++;
        end
        count_chk <= 1'b1;
        write_chk <= wr;
        @(posedge clk);
        count_chk <= 1'b0;
        write_chk <= 1'b0;
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL", tests_run, name);
        end
    endtask

    initial begin
        int mark;
        rst_n        = 1'b0;
        cpu_req      = 1'b0;
        cpu_cmd      = '0;
        started      = 1'b0;
        count_chk    = 1'b0;
        write_chk    = 1'b0;
        exp_rdata    = '0;
        exp_reads    = 0;
        exp_writes   = 0;
        exp_wr_addr  = '0;
        exp_wr_data  = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        mark = errors;
        repeat (10) @(posedge clk);
        report_test("idle after reset", mark);

        mark = errors;
        cpu_access(1'b0, 32'h0000_0104, '0, line_words);
        report_test("read miss", mark);

        // word 7 of the same line
        mark = errors;
        cpu_access(1'b0, 32'h0000_011c, '0, 0);
        report_test("read hit", mark);

        mark = errors;
        cpu_access(1'b1, 32'h0000_0108, 32'hdead_beef, 0);
        cpu_access(1'b0, 32'h0000_0108, '0, 0);
        report_test("write hit", mark);

        // index 5 was never filled
        mark = errors;
        cpu_access(1'b1, 32'h0000_02a4, 32'h1234_5678, 0);
        cpu_access(1'b0, 32'h0000_02a4, '0, line_words);
        report_test("write miss", mark);

        // both map to index 3 with tags 4 and 8
        mark = errors;
        cpu_access(1'b0, 32'h0000_0460, '0, line_words);
        cpu_access(1'b0, 32'h0000_0868, '0, line_words);
        cpu_access(1'b0, 32'h0000_0460, '0, line_words);
        report_test("conflict eviction", mark);

        $display("tests run %0d, tests failing %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !mem_stuck) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- test/mem_model.sv
`timescale 1ns/100ps

module mem_model #(
    parameter cache_pkg::word_t fill_key = 32'h0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_req,
    input  cache_pkg::bus_req_t mem_cmd,
    output logic                mem_ack,
    output cache_pkg::word_t    mem_rdata,
    output int                  rd_count,
    output int                  wr_count,
    output cache_pkg::addr_t    last_wr_addr,
    output cache_pkg::word_t    last_wr_data,
    output logic                stuck
);
    import cache_pkg::*;

    // only written words are stored, the rest follow the fill pattern
    word_t store [addr_t];
    int    seed;
    int    delay;
    int    guard;

    function automatic word_t read_word(input addr_t addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ fill_key;
    endfunction

    initial begin
        seed         = 22;
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        rd_count     = 0;
        wr_count     = 0;
        last_wr_addr = '0;
        last_wr_data = '0;
        stuck        = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && mem_req && !mem_ack) begin
                // access time of 0 to 3 cycles
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk);
                if (mem_cmd.write) begin
                    store[mem_cmd.addr] = mem_cmd.wdata;
                    last_wr_addr <= mem_cmd.addr;
                    last_wr_data <= mem_cmd.wdata;
                    wr_count++;
                end else begin
                    mem_rdata <= read_word(mem_cmd.addr);
                    rd_count++;
                end
                mem_ack <= 1'b1;
                @(posedge clk);
                // hold the ack until the cache lets go of the request
                guard = 0;
                while (mem_req && guard < 64) begin
                    @(posedge clk);
                    guard++;
                end
                if (mem_req) begin
                    $display("memory model: mem_req was never released after mem_ack");
                    stuck <= 1'b1;
                end
                mem_ack <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/cache_l1.sv
`timescale 1ns/100ps

module cache_l1 (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_req,
    input  cache_pkg::bus_req_t cpu_cmd,
    output logic              cpu_ack,
    output cache_pkg::word_t  cpu_rdata,
    output logic              mem_req,
    output cache_pkg::bus_req_t mem_cmd,
    input  logic              mem_ack,
    input  cache_pkg::word_t  mem_rdata
);
    import cache_pkg::*;

    logic       start;
    logic       done;
    cache_req_t held;
    logic       hit;
    word_t      rd_word;
    logic       fill_en;
    word_sel_t  fill_word;
    word_t      fill_data;
    logic       line_valid_en;
    logic       word_wr_en;

    // processor handshake and request capture
    cpu_port i_cpu_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_cmd   (cpu_cmd),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .done      (done),
        .rd_word   (rd_word),
        .start     (start),
        .held      (held)
    );

    cache_store i_cache_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .held          (held),
        .fill_en       (fill_en),
        .fill_word     (fill_word),
        .fill_data     (fill_data),
        .line_valid_en (line_valid_en),
        .word_wr_en    (word_wr_en),
        .hit           (hit),
        .rd_word       (rd_word)
    );

    // sequencing and memory handshake
    cache_ctrl i_cache_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .held          (held),
        .hit           (hit),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .done          (done),
        .mem_req       (mem_req),
        .mem_cmd       (mem_cmd),
        .fill_en       (fill_en),
        .fill_word     (fill_word),
        .fill_data     (fill_data),
        .line_valid_en (line_valid_en),
        .word_wr_en    (word_wr_en)
    );

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  cache_pkg::cache_req_t held,
    input  logic                  hit,
    input  logic                  mem_ack,
    input  cache_pkg::word_t      mem_rdata,
    output logic                  done,
    output logic                  mem_req,
    output cache_pkg::bus_req_t   mem_cmd,
    output logic                  fill_en,
    output cache_pkg::word_sel_t  fill_word,
    output cache_pkg::word_t      fill_data,
    output logic                  line_valid_en,
    output logic                  word_wr_en
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    word_sel_t   fill_cnt;
    addr_t       fill_addr;
    logic        issue;

    // word address inside the line being filled
    assign fill_addr = {held.tag, held.index, fill_cnt, {byte_off_bits{1'b0}}};
    assign fill_word = fill_cnt;
    assign fill_data = mem_rdata;

    always_comb begin
        state_next    = state;
        done          = 1'b0;
        issue         = 1'b0;
        fill_en       = 1'b0;
        line_valid_en = 1'b0;
        word_wr_en    = 1'b0;
        case (state)
            idle: begin
                if (start) begin
                    state_next = lookup;
                end
            end
            lookup: begin
                if (held.write) begin
                    // write-through, cached copy only touched on a hit
                    word_wr_en = hit;
                    state_next = write_req;
                end else if (hit) begin
                    state_next = respond;
                end else begin
                    state_next = fill_req;
                end
            end
            fill_req: begin
                // previous beat must be fully closed first
                if (!mem_ack) begin
                    issue      = 1'b1;
                    state_next = fill_wait;
                end
            end
            fill_wait: begin
                if (mem_ack) begin
                    fill_en = 1'b1;
                    if (fill_cnt == word_sel_t'(line_words - 1)) begin
                        line_valid_en = 1'b1;
                        state_next    = respond;
                    end else begin
                        state_next = fill_req;
                    end
                end
            end
            write_req: begin
                if (!mem_ack) begin
                    issue      = 1'b1;
                    state_next = write_wait;
                end
            end
            write_wait: begin
                if (mem_ack) begin
                    state_next = respond;
                end
            end
            respond: begin
                done       = 1'b1;
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            mem_req  <= 1'b0;
            fill_cnt <= '0;
        end else begin
            state <= state_next;
            if (issue) begin
                mem_req <= 1'b1;
            end else if (mem_ack) begin
                mem_req <= 1'b0;
            end
            if (state == lookup) begin
                fill_cnt <= '0;
            end else if (fill_en) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // command is loaded together with the request edge
    always_ff @(posedge clk) begin
        if (issue) begin
            if (state == write_req) begin
                mem_cmd.write <= 1'b1;
                mem_cmd.addr  <= held.addr;
                mem_cmd.wdata <= held.wdata;
            end else begin
                mem_cmd.write <= 1'b0;
                mem_cmd.addr  <= fill_addr;
                mem_cmd.wdata <= '0;
            end
        end
    end

    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_req && $past(mem_req)) |-> $stable(mem_cmd)
    );

endmodule

//--- verilog/cache_store.sv
`timescale 1ns/100ps

module cache_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::cache_req_t held,
    input  logic                  fill_en,
    input  cache_pkg::word_sel_t  fill_word,
    input  cache_pkg::word_t      fill_data,
    input  logic                  line_valid_en,
    input  logic                  word_wr_en,
    output logic                  hit,
    output cache_pkg::word_t      rd_word
);
    import cache_pkg::*;

    word_t data_arr [cache_lines][line_words];
    tag_t  tag_arr  [cache_lines];
    logic [cache_lines-1:0] valid;

    // lookup on the held index
    assign hit     = valid[held.index] && (tag_arr[held.index] == held.tag);
    assign rd_word = data_arr[held.index][held.word];

    always_ff @(posedge clk) begin
        // line fill, one word per memory beat
        if (fill_en) begin
            data_arr[held.index][fill_word] <= fill_data;
        end
        // write hit keeps the cached copy in step with memory
        if (word_wr_en) begin
            data_arr[held.index][held.word] <= held.wdata;
        end
        if (line_valid_en) begin
            tag_arr[held.index] <= held.tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (line_valid_en) begin
            valid[held.index] <= 1'b1;
        end
    end

    // a line is completed by a fill, a word write only ever follows a hit
    a_no_fill_and_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(line_valid_en && word_wr_en)
    );

endmodule

//--- verilog/cpu_port.sv
`timescale 1ns/100ps

module cpu_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_req,
    input  cache_pkg::bus_req_t   cpu_cmd,
    output logic                  cpu_ack,
    output cache_pkg::word_t      cpu_rdata,
    input  logic                  done,
    input  cache_pkg::word_t      rd_word,
    output logic                  start,
    output cache_pkg::cache_req_t held
);
    import cache_pkg::*;

    // high from request capture until cpu_ack has been released
    logic busy;
    logic accept;

    assign accept = cpu_req && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            start   <= 1'b0;
            cpu_ack <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end
            if (done) begin
                cpu_ack <= 1'b1;
            end else if (cpu_ack && !cpu_req) begin
                // four-phase close, ready for the next request
                cpu_ack <= 1'b0;
                busy    <= 1'b0;
            end
        end
    end

    // split the address once, fields stay put for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            held.write <= cpu_cmd.write;
            held.tag   <= cpu_cmd.addr[31 -: tag_bits];
            held.index <= cpu_cmd.addr[byte_off_bits + word_sel_bits +: index_bits];
            held.word  <= cpu_cmd.addr[byte_off_bits +: word_sel_bits];
            held.wdata <= cpu_cmd.wdata;
            held.addr  <= cpu_cmd.addr;
        end
    end

    // read data is sampled as the access completes
    always_ff @(posedge clk) begin
        if (done) begin
            cpu_rdata <= rd_word;
        end
    end

    // the ack only answers a live request
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cpu_ack) |-> cpu_req
    );

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int cache_lines   = 8;
    localparam int line_words    = 8;
    localparam int byte_off_bits = 2;
    localparam int word_sel_bits = 3;
    localparam int index_bits    = 3;
    // whatever is left of the 32-bit address above index, word and byte fields
    localparam int tag_bits      = 32 - index_bits - word_sel_bits - byte_off_bits;

    typedef logic [31:0]            word_t;
    typedef logic [31:0]            addr_t;
    typedef logic [tag_bits-1:0]    tag_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [word_sel_bits-1:0] word_sel_t;

    // request as seen on the processor port and the memory port
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

    // request held for the duration of one access, address already split
    typedef struct packed {
        logic      write;
        tag_t      tag;
        index_t    index;
        word_sel_t word;
        word_t     wdata;
        addr_t     addr;
    } cache_req_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        fill_req,
        fill_wait,
        write_req,
        write_wait,
        respond
    } ctrl_state_t;

endpackage
